// ==== rtl/counter_4bit.sv ====
`default_nettype none

module counter_4bit (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	input  wire stopwatch_pkg::digit_t i_max,
	input  wire stopwatch_pkg::digit_t i_num,
	input  wire logic                  i_set,
	input  wire logic                  i_inc,
	input  wire logic                  i_paused,
	output stopwatch_pkg::digit_t      o_val,
	output logic                       o_carry
);

	import stopwatch_pkg::*;

	// Load value held within the digit range
	digit_t load_val;

	always_comb begin
		load_val = (i_num > i_max) ? i_max : i_num;
	end

	// Wrap condition seen by the next digit
	always_comb begin
		o_carry = i_inc && !i_paused && (o_val == i_max);
	end

	////////////////////
	// Digit register
	////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_val <= '0;
		end else if (i_set) begin
			// Load wins over increment and ignores pause
			o_val <= load_val;
		end else if (i_inc && !i_paused) begin
			if (o_val == i_max) begin
				o_val <= '0;
			end else begin
				o_val <= o_val + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/display_pkg.sv ====
`default_nettype none

package display_pkg;

	// Segments gfedcba, low lights the segment
	typedef logic [6:0] seg_t;
	// One anode per digit, low enables it
	typedef logic [3:0] anode_t;
	// Scan divider count
	typedef logic [15:0] scan_cnt_t;

	// Cycles per digit, 2 kHz per digit at 100 MHz
	localparam int SCAN_DIV = 50_000;

	// Nothing lit
	localparam seg_t   SEG_BLANK = 7'b111_1111;
	localparam anode_t ANODE_OFF = 4'b1111;

	////////////////////
	// Digit patterns
	////////////////////

	// Index is the BCD value
	localparam seg_t SEG_TABLE [0:9] = '{
		7'b100_0000,
		7'b111_1001,
		7'b010_0100,
		7'b011_0000,
		7'b001_1001,
		7'b001_0010,
		7'b000_0010,
		7'b111_1000,
		7'b000_0000,
		7'b001_0000
	};

endpackage

`default_nettype wire

// ==== rtl/input_conditioner.sv ====
`default_nettype none

module input_conditioner #(
	parameter int DEBOUNCE = stopwatch_pkg::DEBOUNCE_DEFAULT
) (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	input  wire logic                  i_adj,
	input  wire logic                  i_paused,
	input  wire stopwatch_pkg::sel_t   i_sel,
	input  wire stopwatch_pkg::digit_t i_num,
	input  wire logic                  i_btn_inc,
	input  wire logic                  i_btn_load,
	output stopwatch_pkg::controls_t   o_ctrl
);

	import stopwatch_pkg::*;

	// Switch bits {adj, paused, sel, num}
	logic [7:0] sw_s1;
	logic [7:0] sw_s2;

	// Button bits with bit 0 inc and bit 1 load
	logic [1:0] btn_s1;
	logic [1:0] btn_s2;
	logic [1:0] btn_deb;
	logic [1:0] btn_pulse;
	db_cnt_t    btn_cnt [2];

	////////////////////
	// Switches
	////////////////////

	// Two flops only, levels need no debounce
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sw_s1 <= '0;
			sw_s2 <= '0;
		end else begin
			sw_s1 <= {i_adj, i_paused, i_sel, i_num};
			sw_s2 <= sw_s1;
		end
	end

	////////////////////
	// Buttons
	////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			btn_s1    <= '0;
			btn_s2    <= '0;
			btn_deb   <= '0;
			btn_pulse <= '0;
			for (int b = 0; b < 2; b++) begin
				btn_cnt[b] <= '0;
			end
		end else begin
			btn_s1 <= {i_btn_load, i_btn_inc};
			btn_s2 <= btn_s1;
			for (int b = 0; b < 2; b++) begin
				btn_pulse[b] <= 1'b0;
				if (btn_s2[b] == btn_deb[b]) begin
					// Level agrees so restart the stability count
					btn_cnt[b] <= '0;
				end else if (btn_cnt[b] == db_cnt_t'(DEBOUNCE - 1)) begin
					// Held long enough to accept the new level
					btn_cnt[b]   <= '0;
					btn_deb[b]   <= btn_s2[b];
					// Pulse on press only
					btn_pulse[b] <= btn_s2[b];
				end else begin
					btn_cnt[b] <= btn_cnt[b] + 1'b1;
				end
			end
		end
	end

	// Pack the conditioned inputs
	always_comb begin
		o_ctrl.adj        = sw_s2[7];
		o_ctrl.paused     = sw_s2[6];
		o_ctrl.sel        = sw_s2[5:4];
		o_ctrl.num        = sw_s2[3:0];
		o_ctrl.inc_pulse  = btn_pulse[0];
		o_ctrl.load_pulse = btn_pulse[1];
	end

endmodule

`default_nettype wire

// ==== rtl/seg7_scan.sv ====
`default_nettype none

module seg7_scan (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst,
	input  wire stopwatch_pkg::time_digits_t i_val,
	output display_pkg::seg_t                o_seg,
	output display_pkg::anode_t              o_an
);

	import stopwatch_pkg::*;
	import display_pkg::*;

	// Cycles spent on the current digit
	scan_cnt_t scan_cnt;
	// Digit being shown
	sel_t      scan_idx;
	// Value of that digit
	digit_t    cur_digit;

	////////////////////
	// Scan timing
	////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			scan_cnt <= '0;
			scan_idx <= '0;
		end else if (scan_cnt == scan_cnt_t'(SCAN_DIV - 1)) begin
			// Next digit in the order 0, 1, 2, 3
			scan_cnt <= '0;
			scan_idx <= scan_idx + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// Digit select
	always_comb begin
		case (scan_idx)
			2'd0:    cur_digit = i_val.sec_ones;
			2'd1:    cur_digit = i_val.sec_tens;
			2'd2:    cur_digit = i_val.min_ones;
			default: cur_digit = i_val.min_tens;
		endcase
	end

	////////////////////
	// Output registers
	////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			// Display dark while in reset
			o_seg <= SEG_BLANK;
			o_an  <= ANODE_OFF;
		end else begin
			// Non BCD codes stay dark
			o_seg <= (cur_digit <= 4'd9) ? SEG_TABLE[cur_digit] : SEG_BLANK;
			// One anode low
			o_an  <= ~(anode_t'(1) << scan_idx);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/stopwatch_logic.sv ====
`default_nettype none

module stopwatch_logic (
	input  wire logic                     i_clk,
	input  wire logic                     i_rst,
	input  wire logic                     i_tick,
	input  wire stopwatch_pkg::controls_t i_ctrl,
	output stopwatch_pkg::time_digits_t   o_val
);

	import stopwatch_pkg::*;

	// One hot of the selected digit
	logic [3:0] sel_hit;
	// Per digit load and increment
	logic [3:0] set_en;
	logic [3:0] inc_en;
	// Carry out of digits 0 to 2
	logic [2:0] carry;
	// Digit values with index 0 as seconds ones
	digit_t     dig [4];

	////////////////////
	// Enable decode
	////////////////////

	always_comb begin
		sel_hit = 4'b0001 << i_ctrl.sel;
		// Loads only in adjust mode
		set_en  = (i_ctrl.adj && i_ctrl.load_pulse) ? sel_hit : 4'b0000;
		if (i_ctrl.adj) begin
			// Hand stepping with tick and carries blocked
			inc_en = i_ctrl.inc_pulse ? sel_hit : 4'b0000;
		end else begin
			// Tick into seconds ones and carries ripple upward
			inc_en = {carry, i_tick};
		end
	end

	////////////////////
	// Digit chain
	////////////////////

	counter_4bit u_sec_ones (
		.i_clk(i_clk), .i_rst(i_rst), .i_max(DIGIT_MAX_SEC_ONES), .i_num(i_ctrl.num),
		.i_set(set_en[0]), .i_inc(inc_en[0]), .i_paused(i_ctrl.paused),
		.o_val(dig[0]), .o_carry(carry[0])
	);

	counter_4bit u_sec_tens (
		.i_clk(i_clk), .i_rst(i_rst), .i_max(DIGIT_MAX_SEC_TENS), .i_num(i_ctrl.num),
		.i_set(set_en[1]), .i_inc(inc_en[1]), .i_paused(i_ctrl.paused),
		.o_val(dig[1]), .o_carry(carry[1])
	);

	counter_4bit u_min_ones (
		.i_clk(i_clk), .i_rst(i_rst), .i_max(DIGIT_MAX_MIN_ONES), .i_num(i_ctrl.num),
		.i_set(set_en[2]), .i_inc(inc_en[2]), .i_paused(i_ctrl.paused),
		.o_val(dig[2]), .o_carry(carry[2])
	);

	// Top digit wraps 59:59 to 00:00 with nothing above it
	counter_4bit u_min_tens (
		.i_clk(i_clk), .i_rst(i_rst), .i_max(DIGIT_MAX_MIN_TENS), .i_num(i_ctrl.num),
		.i_set(set_en[3]), .i_inc(inc_en[3]), .i_paused(i_ctrl.paused),
		.o_val(dig[3]), .o_carry()
	);

	assign o_val = {dig[3], dig[2], dig[1], dig[0]};

endmodule

`default_nettype wire

// ==== rtl/stopwatch_pkg.sv ====
`default_nettype none

package stopwatch_pkg;

	////////////////////
	// Plain types
	////////////////////

	// One BCD digit
	typedef logic [3:0] digit_t;
	// Digit index with 0 as seconds ones
	typedef logic [1:0] sel_t;
	// Wide enough for 100M cycles per tick
	typedef logic [26:0] tick_cnt_t;
	// Wide enough for 1M cycles of button stability
	typedef logic [19:0] db_cnt_t;

	// Highest value of each digit
	localparam digit_t DIGIT_MAX_SEC_ONES = 4'd9;
	localparam digit_t DIGIT_MAX_SEC_TENS = 4'd5;
	localparam digit_t DIGIT_MAX_MIN_ONES = 4'd9;
	localparam digit_t DIGIT_MAX_MIN_TENS = 4'd5;

	// One second at 100 MHz
	localparam int TICK_DIV_DEFAULT = 100_000_000;
	// About 10 ms of stable level
	localparam int DEBOUNCE_DEFAULT = 1_000_000;

	////////////////////
	// Bundles
	////////////////////

	// MM:SS with minutes tens in the top nibble
	typedef struct packed {
		digit_t min_tens;
		digit_t min_ones;
		digit_t sec_tens;
		digit_t sec_ones;
	} time_digits_t;

	// Conditioned user input
	typedef struct packed {
		logic   adj;
		logic   paused;
		sel_t   sel;
		digit_t num;
		logic   inc_pulse;
		logic   load_pulse;
	} controls_t;

endpackage

`default_nettype wire

// ==== rtl/stopwatch_top.sv ====
`default_nettype none

module stopwatch_top #(
	parameter int TICK_DIV = stopwatch_pkg::TICK_DIV_DEFAULT,
	parameter int DEBOUNCE = stopwatch_pkg::DEBOUNCE_DEFAULT
) (
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	// Switches
	input  wire logic                  i_adj,
	input  wire logic                  i_paused,
	input  wire stopwatch_pkg::sel_t   i_sel,
	input  wire stopwatch_pkg::digit_t i_num,
	// Buttons
	input  wire logic                  i_btn_inc,
	input  wire logic                  i_btn_load,
	// Current time and display
	output stopwatch_pkg::time_digits_t o_val,
	output display_pkg::seg_t           o_seg,
	output display_pkg::anode_t         o_an
);

	import stopwatch_pkg::*;

	// Conditioned switches and button pulses
	controls_t ctrl;
	// One second enable
	logic      tick;

	////////////////////
	// Front end
	////////////////////

	input_conditioner #(
		.DEBOUNCE(DEBOUNCE)
	) u_input_conditioner (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_adj(i_adj), .i_paused(i_paused), .i_sel(i_sel), .i_num(i_num),
		.i_btn_inc(i_btn_inc), .i_btn_load(i_btn_load),
		.o_ctrl(ctrl)
	);

	tick_gen #(
		.TICK_DIV(TICK_DIV)
	) u_tick_gen (
		.i_clk(i_clk), .i_rst(i_rst), .o_tick(tick)
	);

	////////////////////
	// Counting and display
	////////////////////

	stopwatch_logic u_stopwatch_logic (
		.i_clk(i_clk), .i_rst(i_rst), .i_tick(tick), .i_ctrl(ctrl), .o_val(o_val)
	);

	// Scanner shows the same time as o_val
	seg7_scan u_seg7_scan (
		.i_clk(i_clk), .i_rst(i_rst), .i_val(o_val), .o_seg(o_seg), .o_an(o_an)
	);

endmodule

`default_nettype wire

// ==== rtl/tick_gen.sv ====
`default_nettype none

module tick_gen #(
	parameter int TICK_DIV = stopwatch_pkg::TICK_DIV_DEFAULT
) (
	input  wire logic i_clk,
	input  wire logic i_rst,
	output logic      o_tick
);

	import stopwatch_pkg::*;

	// Cycles left until the next tick
	tick_cnt_t tick_cnt;

	////////////////////
	// Down counter
	////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			// Full period before the first tick
			tick_cnt <= tick_cnt_t'(TICK_DIV - 1);
			o_tick   <= 1'b0;
		end else if (tick_cnt == '0) begin
			// Reload and fire for one cycle
			tick_cnt <= tick_cnt_t'(TICK_DIV - 1);
			o_tick   <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt - 1'b1;
			o_tick   <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/stopwatch_pkg.sv
rtl/display_pkg.sv
rtl/tick_gen.sv
rtl/input_conditioner.sv
rtl/counter_4bit.sv
rtl/stopwatch_logic.sv
rtl/seg7_scan.sv
rtl/stopwatch_top.sv
tb/stopwatch_checker.sv
tb/stopwatch_tb.sv

// ==== tb/stopwatch_checker.sv ====
`default_nettype none

module stopwatch_checker (
	input  wire logic                        i_clk,
	input  wire logic                        i_rst,
	input  wire stopwatch_pkg::time_digits_t i_val,
	input  wire display_pkg::seg_t           i_seg,
	input  wire display_pkg::anode_t         i_an,
	input  wire logic                        i_check,
	input  wire stopwatch_pkg::time_digits_t i_exp,
	input  wire logic                        i_scan,
	input  wire logic                        i_test_end,
	input  wire logic [7:0]                  i_test_id,
	output int                               o_checks,
	output int                               o_errors,
	output int                               o_passed,
	output int                               o_failed
);

	timeunit 1ns;
	timeprecision 1ps;

	import stopwatch_pkg::*;
	import display_pkg::*;

	logic   reset_edge_seen = 1'b0;
	logic   scan_prev = 1'b0;
	int     checks = 0;
	int     errors = 0;
	int     passed = 0;
	int     failed = 0;
	int     test_checks = 0;
	int     test_errors = 0;
	// Cycles each anode was low during a sweep
	int     low_cnt [4] = '{0, 0, 0, 0};
	int     an_idx;
	int     last_idx = -1;
	seg_t   exp_seg;

	assign o_checks = checks;
	assign o_errors = errors;
	assign o_passed = passed;
	assign o_failed = failed;

	////////////////////
	// Reference models
	////////////////////

	// Active low gfedcba from which digits light each segment
	function automatic seg_t seg_pattern(input digit_t d);
		logic [9:0] lit_a;
		logic [9:0] lit_b;
		logic [9:0] lit_c;
		logic [9:0] lit_d;
		logic [9:0] lit_e;
		logic [9:0] lit_f;
		logic [9:0] lit_g;
		// Bit n set when digit n lights the segment
		lit_a = 10'b11_1110_1101;
		lit_b = 10'b11_1001_1111;
		lit_c = 10'b11_1111_1011;
		lit_d = 10'b11_0110_1101;
		lit_e = 10'b01_0100_0101;
		lit_f = 10'b11_0111_0001;
		lit_g = 10'b11_0111_1100;
		return ~{lit_g[d], lit_f[d], lit_e[d], lit_d[d], lit_c[d], lit_b[d], lit_a[d]};
	endfunction

	// Index 0 is seconds ones
	function automatic digit_t digit_at(input time_digits_t t, input int idx);
		case (idx)
			0:       return t.sec_ones;
			1:       return t.sec_tens;
			2:       return t.min_ones;
			default: return t.min_tens;
		endcase
	endfunction

	////////////////////
	// Display sweep
	////////////////////

	task automatic sample_display();
		case (i_an)
			4'b1110: an_idx = 0;
			4'b1101: an_idx = 1;
			4'b1011: an_idx = 2;
			4'b0111: an_idx = 3;
			default: an_idx = -1;
		endcase
		if (an_idx < 0) begin
			$display("Display fault at %0t, o_an %b does not select one digit", $time, i_an);
			test_errors++;
		end else begin
			// Scan order 0, 1, 2, 3 and around
			if (last_idx >= 0 && an_idx != last_idx && an_idx != (last_idx + 1) % 4) begin
				$display("Display fault at %0t, digit %0d followed digit %0d",
					$time, an_idx, last_idx);
				test_errors++;
			end
			last_idx = an_idx;
			low_cnt[an_idx]++;
			exp_seg = seg_pattern(digit_at(i_val, an_idx));
			if (i_seg !== exp_seg) begin
				$display("ERR %0t o_seg expected %b got %b", $time, exp_seg, i_seg);
				test_errors++;
			end
		end
	endtask

	// Each anode owns a quarter of the window
	task automatic close_sweep();
		test_checks++;
		for (int a = 0; a < 4; a++) begin
			if (low_cnt[a] != SCAN_DIV) begin
				$display("Anode %0d was active for %0d cycles instead of %0d",
					a, low_cnt[a], SCAN_DIV);
				test_errors++;
			end
			low_cnt[a] = 0;
		end
		last_idx = -1;
	endtask

	task automatic close_test();
		if (test_errors == 0) begin
			$display("test %0d passed, %0d checks", i_test_id, test_checks);
			passed++;
		end else begin
			$display("test %0d failed, %0d errors in %0d checks",
				i_test_id, test_errors, test_checks);
			failed++;
		end
		checks += test_checks;
		errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	always @(posedge i_clk) begin
		if (i_rst) begin
			reset_edge_seen <= 1'b1;
		end
	end

	// Outputs settle between edges
	always @(negedge i_clk) begin
		// Dark display and cleared time once reset has been clocked
		if (i_rst && reset_edge_seen) begin
			test_checks++;
			if (i_an !== 4'b1111) begin
				$display("ERR %0t o_an expected 1111 got %b", $time, i_an);
				test_errors++;
			end
			if (i_val !== 16'h0000) begin
				$display("ERR %0t o_val expected 0000 got %h", $time, i_val);
				test_errors++;
			end
		end
		if (i_scan) begin
			sample_display();
		end else if (scan_prev) begin
			close_sweep();
		end
		scan_prev = i_scan;
		if (i_check) begin
			test_checks++;
			if (i_val !== i_exp) begin
				$display("ERR %0t o_val expected %h got %h", $time, i_exp, i_val);
				test_errors++;
			end
		end
		if (i_test_end) begin
			close_test();
		end
	end

endmodule

`default_nettype wire

// ==== tb/stopwatch_tb.sv ====
`default_nettype none

module stopwatch_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import stopwatch_pkg::*;
	import display_pkg::*;

	// Short periods so a tick is ten cycles
	localparam int TICK_DIV      = 10;
	localparam int DEBOUNCE      = 4;
	localparam int RESET_CYCLES  = 8;
	// Slack on top of the summed hold counts
	localparam int TIMEOUT_SLACK = 100;

	// One line of the vector file
	typedef struct packed {
		logic [7:0]   test;
		logic         adj;
		logic         paused;
		sel_t         sel;
		digit_t       num;
		logic         inc;
		logic         load;
		logic [31:0]  hold;
		logic [1:0]   check;
		time_digits_t expected;
	} step_t;

	logic         clk = 1'b0;
	logic         rst;
	logic         adj;
	logic         paused;
	sel_t         sel;
	digit_t       num;
	logic         btn_inc;
	logic         btn_load;
	time_digits_t dut_val;
	seg_t         dut_seg;
	anode_t       dut_an;

	// Requests to the checker
	logic         check_en;
	time_digits_t check_exp;
	logic         scan_en;
	logic         test_end;
	logic [7:0]   test_id;

	// Totals kept by the checker
	int n_checks;
	int n_errors;
	int n_passed;
	int n_failed;

	step_t steps [$];
	int    cycle_cnt = 0;
	int    cycle_limit = 0;

	// 40 ns period
	always #20 clk = ~clk;

	stopwatch_top #(
		.TICK_DIV(TICK_DIV),
		.DEBOUNCE(DEBOUNCE)
	) stopwatch_top_inst (
		.i_clk(clk), .i_rst(rst),
		.i_adj(adj), .i_paused(paused), .i_sel(sel), .i_num(num),
		.i_btn_inc(btn_inc), .i_btn_load(btn_load),
		.o_val(dut_val), .o_seg(dut_seg), .o_an(dut_an)
	);

	stopwatch_checker stopwatch_checker_inst (
		.i_clk(clk), .i_rst(rst), .i_val(dut_val), .i_seg(dut_seg), .i_an(dut_an),
		.i_check(check_en), .i_exp(check_exp), .i_scan(scan_en),
		.i_test_end(test_end), .i_test_id(test_id),
		.o_checks(n_checks), .o_errors(n_errors), .o_passed(n_passed), .o_failed(n_failed)
	);

	////////////////////
	// Vector reading
	////////////////////

	task automatic load_vectors(output bit ok);
		int    fd;
		int    fields;
		int    f [9];
		logic [15:0] f_exp;
		string line;
		step_t st;
		ok = 1'b0;
		fd = $fopen("tb/stopwatch_vectors.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				// Lines starting with # are column notes
				if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f_exp);
					if (fields == 10) begin
						st.test     = f[0][7:0];
						st.adj      = f[1][0];
						st.paused   = f[2][0];
						st.sel      = f[3][1:0];
						st.num      = f[4][3:0];
						st.inc      = f[5][0];
						st.load     = f[6][0];
						st.hold     = f[7];
						st.check    = f[8][1:0];
						st.expected = f_exp;
						steps.push_back(st);
					end
				end
			end
			$fclose(fd);
			ok = (steps.size() > 0);
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	// Drive one step, hold it, then ask for a compare if flagged
	task automatic run_step(input step_t st);
		adj      <= st.adj;
		paused   <= st.paused;
		sel      <= st.sel;
		num      <= st.num;
		btn_inc  <= st.inc;
		btn_load <= st.load;
		test_id  <= st.test;
		// Check mode 2 sweeps the display over the whole hold
		scan_en  <= (st.check == 2'd2);
		repeat (st.hold) @(posedge clk);
		scan_en <= 1'b0;
		if (st.check != 2'd0) begin
			check_en  <= 1'b1;
			check_exp <= st.expected;
			@(posedge clk);
			check_en <= 1'b0;
		end
	endtask

	task automatic announce_test_end();
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	// Run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout after %0d clock cycles with the vectors not finished", cycle_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		bit ok;
		int hold_sum;
		// Adjust mode at start so nothing counts before the first step
		rst       = 1'b1;
		adj       = 1'b1;
		paused    = 1'b0;
		sel       = '0;
		num       = '0;
		btn_inc   = 1'b0;
		btn_load  = 1'b0;
		check_en  = 1'b0;
		check_exp = '0;
		scan_en   = 1'b0;
		test_end  = 1'b0;
		test_id   = '0;
		load_vectors(ok);
		hold_sum = 0;
		foreach (steps[i]) hold_sum += steps[i].hold;
		// Each step adds at most a check cycle and a test end cycle
		cycle_limit = RESET_CYCLES + hold_sum + 2 * steps.size() + TIMEOUT_SLACK;
		if (!ok) begin
			$display("No steps could be read from tb/stopwatch_vectors.txt");
			$display("Test FAILED");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(posedge clk);
			rst <= 1'b0;
			foreach (steps[i]) begin
				if (i > 0 && steps[i].test != steps[i - 1].test) begin
					announce_test_end();
				end
				run_step(steps[i]);
			end
			announce_test_end();
			@(posedge clk);
			$display("Tests passed %0d, failed %0d; checks %0d, errors %0d",
				n_passed, n_failed, n_checks, n_errors);
			if (n_errors == 0 && n_failed == 0 && n_passed > 0) begin
				$display("Test OK");
			end else begin
				$display("Test FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb/stopwatch_vectors.txt ====
# test adj paused sel num inc load hold check expected(hex MM:SS)
# check 0 none, 1 compare o_val after the hold, 2 also sweep the display during the hold
1 1 0 0 0 0 0 4 1 0000
2 1 0 1 7 0 1 8 0 0000
2 1 0 1 7 0 0 8 1 0050
2 1 0 2 3 0 1 8 0 0000
2 1 0 2 3 0 0 8 1 0350
3 1 0 0 9 0 1 8 0 0000
3 1 0 0 9 0 0 8 1 0359
3 1 0 0 9 1 0 8 0 0000
3 1 0 0 9 0 0 8 1 0350
4 1 0 2 9 0 1 8 0 0000
4 1 0 2 9 0 0 8 0 0000
4 1 0 0 8 0 1 8 0 0000
4 1 0 0 8 0 0 8 1 0958
4 0 0 0 8 0 0 30 0 0000
4 0 1 0 8 0 0 10 1 1001
5 0 1 0 8 0 0 50 1 1001
5 1 1 3 5 0 1 8 0 0000
5 1 1 3 5 0 0 8 0 0000
5 1 1 2 9 0 1 8 0 0000
5 1 1 2 9 0 0 8 0 0000
5 1 1 1 9 0 1 8 0 0000
5 1 1 1 9 0 0 8 0 0000
5 1 1 0 9 0 1 8 0 0000
5 1 1 0 9 0 0 8 1 5959
5 0 0 0 9 0 0 10 0 0000
5 0 1 0 9 0 0 10 1 0000
6 1 1 3 4 0 1 8 0 0000
6 1 1 3 4 0 0 8 0 0000
6 1 1 2 2 0 1 8 0 0000
6 1 1 2 2 0 0 8 0 0000
6 1 1 1 1 0 1 8 0 0000
6 1 1 1 1 0 0 8 0 0000
6 1 1 0 7 0 1 8 0 0000
6 1 1 0 7 0 0 8 1 4217
6 1 1 0 7 0 0 200000 2 4217
